/* common/jpeg_mcu_pkg.sv */
`default_nettype none

package jpeg_mcu_pkg;

    // bits per sample, all three components
    parameter int PIX_W = 8;

    // pixels per block row, one ram word holds one row
    parameter int ROW_PIX = 8;
    parameter int ROW_W   = ROW_PIX * PIX_W;

    // jpeg level shift, subtracted from every sample before storage
    parameter logic [PIX_W-1:0] JPEG_BIAS = PIX_W'(128);

    // one raster pixel, cb and cr only meaningful on even column of even line
    typedef struct packed {
        logic [PIX_W-1:0] y;
        logic [PIX_W-1:0] cb;
        logic [PIX_W-1:0] cr;
    } pix_t;

    // per component valid, same field order as pix_t
    typedef struct packed {
        logic y;
        logic cb;
        logic cr;
    } pix_valid_t;

    // eight biased samples of one block row
    // s[0] is the leftmost pixel and sits in the low byte
    typedef struct packed {
        logic [ROW_PIX-1:0][PIX_W-1:0] s;
    } row_t;

    // block order inside one 4:2:0 mcu
    typedef enum logic [2:0] {
        BLK_Y0 = 3'd0,
        BLK_Y1 = 3'd1,
        BLK_Y2 = 3'd2,
        BLK_Y3 = 3'd3,
        BLK_CB = 3'd4,
        BLK_CR = 3'd5
    } blk_phase_e;

endpackage

`default_nettype wire

/* verilog/dp_ram_be.sv */
`timescale 1ns/1ps
`default_nettype none

module dp_ram_be #(
    parameter int DW    = 64,
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] wa_i,
    input  logic [DW-1:0]            wd_i,
    input  logic [DW/8-1:0]          wbe_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] ra_i,
    input  logic                     re_i,
    output logic [DW-1:0]            rd_o
);

    logic [DW-1:0] mem [DEPTH];

    // byte lanes are written independently
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < DW/8; b++) begin
                if (wbe_i[b]) begin
                    mem[wa_i][b*8 +: 8] <= wd_i[b*8 +: 8];
                end
            end
        end
    end

    // registered read, data holds while re_i is low
    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_o <= mem[ra_i];
        end
    end

    // addresses are built from counters, so depth must cover the top value
    a_wa_in_range: assert property (@(posedge clk) we_i |-> (int'(wa_i) < DEPTH));

endmodule

`default_nettype wire

/* verilog/raster_position.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_position #(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  jpeg_mcu_pkg::pix_valid_t         pix_valid_i,
    input  logic                             hold_i,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1_i,
    output logic [$clog2(SENSOR_X_SIZE)-1:0] pixel_count_o,
    output logic [$clog2(SENSOR_Y_SIZE)-1:0] line_count_o,
    output logic                             eof_o
);

    localparam int XW = $clog2(SENSOR_X_SIZE);
    localparam int YW = $clog2(SENSOR_Y_SIZE);

    logic [XW-1:0] col;
    logic [YW-1:0] line;
    logic          accept;
    logic          last_col;
    logic          last_line;

    // a pixel moves on only when luma is present and the buffer takes it
    assign accept    = pix_valid_i.y && !hold_i;
    assign last_col  = (col == x_size_m1_i);
    assign last_line = (line == y_size_m1_i);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            col   <= '0;
            line  <= '0;
            eof_o <= 1'b0;
        end else begin
            // eof is a single cycle pulse after the last pixel
            eof_o <= accept && last_col && last_line;
            if (accept) begin
                if (last_col) begin
                    col <= '0;
                    // wrap to the top of the next frame
                    if (last_line) begin
                        line <= '0;
                    end else begin
                        line <= line + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // position of the pixel currently on the input
    assign pixel_count_o = col;
    assign line_count_o  = line;

    // 4:2:0 siting, chroma only on even columns of even lines
    a_chroma_siting: assert property (@(posedge clk) disable iff (!resetn)
        (pix_valid_i.cb || pix_valid_i.cr) |-> (!col[0] && !line[0]));

endmodule

`default_nettype wire

/* mcu_buffer/mcu_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_buffer #(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  jpeg_mcu_pkg::pix_t               pix_i,
    input  jpeg_mcu_pkg::pix_valid_t         pix_valid_i,
    output logic                             hold_o,
    input  logic                             eof_i,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] pixel_count_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] line_count_i,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1_i,
    output jpeg_mcu_pkg::row_t               row_o,
    output logic                             row_valid_o,
    input  logic                             hold_i,
    output logic [2:0]                       row_idx_o
);

    import jpeg_mcu_pkg::*;

    localparam int XW = $clog2(SENSOR_X_SIZE);
    localparam int YW = $clog2(SENSOR_Y_SIZE);

    // two slots of 16 luma lines, eight pixels per word
    localparam int Y_DEPTH = 2 * SENSOR_X_SIZE * 16 / ROW_PIX;
    localparam int Y_AW    = $clog2(Y_DEPTH);

    // two slots times two components of 8 half width lines
    localparam int UV_DEPTH = 2 * 2 * (SENSOR_X_SIZE / 2) * 8 / ROW_PIX;
    localparam int UV_AW    = $clog2(UV_DEPTH);

    // slot fifo, one extra pointer bit tells full from empty
    logic [1:0] wptr;
    logic [1:0] rptr;
    logic       full;
    logic       empty;

    // write side
    logic               y_accept;
    logic               cb_accept;
    logic               cr_accept;
    logic               strip_end_line;
    logic               commit;
    logic [PIX_W-1:0]   y_biased;
    logic [PIX_W-1:0]   cb_biased;
    logic [PIX_W-1:0]   cr_biased;
    logic [Y_AW-1:0]    y_wa;
    logic [ROW_PIX-1:0] y_wbe;
    logic [UV_AW-1:0]   cb_wa;
    logic [ROW_PIX-1:0] c_wbe;

    // cr holding register for the shared chroma write port
    logic [UV_AW-1:0]   cr_wa_q;
    logic [PIX_W-1:0]   cr_wd_q;
    logic [ROW_PIX-1:0] cr_wbe_q;
    logic               cr_we_q;

    logic [UV_AW-1:0]   uv_wa;
    logic [ROW_W-1:0]   uv_wd;
    logic [ROW_PIX-1:0] uv_wbe;
    logic               uv_we;

    // read side
    logic [2:0]    row;
    blk_phase_e    phase;
    blk_phase_e    phase_q;
    logic [XW-5:0] mb_col;
    logic [YW-5:0] strip;
    logic          rd_step;
    logic          rd_luma;
    logic          mb_last;
    logic          strip_last;
    logic          release_slot;
    logic [Y_AW-1:0]  y_ra;
    logic [UV_AW-1:0] uv_ra;
    logic [ROW_W-1:0] rd_y;
    logic [ROW_W-1:0] rd_uv;

    assign empty  = (wptr == rptr);
    assign full   = (wptr[1] != rptr[1]) && (wptr[0] == rptr[0]);
    // the source stalls while both strips wait for readout
    assign hold_o = full;

    assign y_accept  = pix_valid_i.y && !full;
    assign cb_accept = pix_valid_i.cb && !full;
    assign cr_accept = pix_valid_i.cr && !full;

    // strip ends on line 15 or on the frame's last line
    assign strip_end_line = (line_count_i[3:0] == 4'hf) || (line_count_i == y_size_m1_i);
    assign commit = y_accept && strip_end_line && (pixel_count_i == x_size_m1_i);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr <= '0;
        end else if (commit) begin
            wptr <= wptr + 1'b1;
        end
    end

    assign y_biased  = pix_i.y - JPEG_BIAS;
    assign cb_biased = pix_i.cb - JPEG_BIAS;
    assign cr_biased = pix_i.cr - JPEG_BIAS;

    // luma word: column/8, line within strip, slot
    assign y_wa  = {pixel_count_i[XW-1:3], line_count_i[3:0], wptr[0]};
    assign y_wbe = ROW_PIX'(1) << pixel_count_i[2:0];

    // chroma word: column/16, chroma line within strip, slot, component
    // lsb of the address selects cb (0) or cr (1)
    assign cb_wa = {pixel_count_i[XW-1:4], line_count_i[3:1], wptr[0], 1'b0};
    assign c_wbe = ROW_PIX'(1) << pixel_count_i[3:1];

    // cr is parked one cycle and written behind cb
    always_ff @(posedge clk) begin
        if (cr_accept) begin
            cr_wa_q  <= {pixel_count_i[XW-1:4], line_count_i[3:1], wptr[0], 1'b1};
            cr_wd_q  <= cr_biased;
            cr_wbe_q <= c_wbe;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cr_we_q <= 1'b0;
        end else begin
            cr_we_q <= cr_accept;
        end
    end

    // pending cr wins the write port
    assign uv_wa  = cr_we_q ? cr_wa_q : cb_wa;
    assign uv_wd  = cr_we_q ? {ROW_PIX{cr_wd_q}} : {ROW_PIX{cb_biased}};
    assign uv_wbe = cr_we_q ? cr_wbe_q : c_wbe;
    assign uv_we  = cr_we_q || cb_accept;

    // read sequencer walks row, block, macroblock and strip
    assign rd_step      = !hold_i && !empty;
    assign rd_luma      = (phase != BLK_CB) && (phase != BLK_CR);
    assign mb_last      = (mb_col == x_size_m1_i[XW-1:4]);
    assign strip_last   = (strip == y_size_m1_i[YW-1:4]);
    assign release_slot = rd_step && (row == 3'd7) && (phase == BLK_CR) && mb_last;

    always_ff @(posedge clk) begin
        if (!resetn || eof_i) begin
            row    <= '0;
            phase  <= BLK_Y0;
            mb_col <= '0;
            strip  <= '0;
        end else if (rd_step) begin
            row <= row + 1'b1;
            if (row == 3'd7) begin
                if (phase == BLK_CR) begin
                    phase <= BLK_Y0;
                    if (mb_last) begin
                        mb_col <= '0;
                        strip  <= strip_last ? '0 : strip + 1'b1;
                    end else begin
                        mb_col <= mb_col + 1'b1;
                    end
                end else begin
                    phase <= blk_phase_e'(phase + 3'd1);
                end
            end
        end
    end

    // the slot goes back to the writer after the last cr row
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr <= '0;
        end else if (release_slot) begin
            rptr <= rptr + 1'b1;
        end
    end

    // phase bit 0 picks the right 8 columns, bit 1 the lower 8 lines
    assign y_ra  = {mb_col, phase[0], phase[1], row, rptr[0]};
    assign uv_ra = {mb_col, row, rptr[0], (phase == BLK_CR)};

    dp_ram_be #(
        .DW    (ROW_W),
        .DEPTH (Y_DEPTH)
    ) y_buf (
        .clk   (clk),
        .wa_i  (y_wa),
        .wd_i  ({ROW_PIX{y_biased}}),
        .wbe_i (y_wbe),
        .we_i  (y_accept),
        .ra_i  (y_ra),
        .re_i  (rd_step && rd_luma),
        .rd_o  (rd_y)
    );

    dp_ram_be #(
        .DW    (ROW_W),
        .DEPTH (UV_DEPTH)
    ) uv_buf (
        .clk   (clk),
        .wa_i  (uv_wa),
        .wd_i  (uv_wd),
        .wbe_i (uv_wbe),
        .we_i  (uv_we),
        .ra_i  (uv_ra),
        .re_i  (rd_step && !rd_luma),
        .rd_o  (rd_uv)
    );

    // phase and row index follow the ram read by one cycle
    always_ff @(posedge clk) begin
        if (rd_step) begin
            phase_q   <= phase;
            row_idx_o <= row;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || eof_i) begin
            row_valid_o <= 1'b0;
        end else if (!hold_i) begin
            row_valid_o <= !empty;
        end
    end

    assign row_o = row_t'(((phase_q == BLK_CB) || (phase_q == BLK_CR)) ? rd_uv : rd_y);

    // the writer must not move into a slot still being read
    // so the raster position stands still while both slots are full
    a_no_commit_full: assert property (@(posedge clk) disable iff (!resetn)
        full |=> ($stable(pixel_count_i) && $stable(line_count_i)));

    a_phase_legal: assert property (@(posedge clk) disable iff (!resetn)
        phase inside {BLK_Y0, BLK_Y1, BLK_Y2, BLK_Y3, BLK_CB, BLK_CR});

    // frame height stays fixed while its strips are read out
    a_strip_in_frame: assert property (@(posedge clk) disable iff (!resetn)
        !empty |-> (strip <= y_size_m1_i[YW-1:4]));

endmodule

`default_nettype wire

/* verilog/jpeg_mcu_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module jpeg_mcu_frontend #(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  jpeg_mcu_pkg::pix_t               pix_i,
    input  jpeg_mcu_pkg::pix_valid_t         pix_valid_i,
    output logic                             hold_o,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1_i,
    output jpeg_mcu_pkg::row_t               row_o,
    output logic                             row_valid_o,
    output logic [2:0]                       row_idx_o,
    input  logic                             hold_i
);

    // position of the current input pixel
    logic [$clog2(SENSOR_X_SIZE)-1:0] pixel_count;
    logic [$clog2(SENSOR_Y_SIZE)-1:0] line_count;
    logic                             eof;

    raster_position #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) i_raster_position (
        .clk           (clk),
        .resetn        (resetn),
        .pix_valid_i   (pix_valid_i),
        .hold_i        (hold_o),
        .x_size_m1_i   (x_size_m1_i),
        .y_size_m1_i   (y_size_m1_i),
        .pixel_count_o (pixel_count),
        .line_count_o  (line_count),
        .eof_o         (eof)
    );

    // strip store and mcu order readout
    mcu_buffer #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) i_mcu_buffer (
        .clk           (clk),
        .resetn        (resetn),
        .pix_i         (pix_i),
        .pix_valid_i   (pix_valid_i),
        .hold_o        (hold_o),
        .eof_i         (eof),
        .pixel_count_i (pixel_count),
        .line_count_i  (line_count),
        .x_size_m1_i   (x_size_m1_i),
        .y_size_m1_i   (y_size_m1_i),
        .row_o         (row_o),
        .row_valid_o   (row_valid_o),
        .hold_i        (hold_i),
        .row_idx_o     (row_idx_o)
    );

endmodule

`default_nettype wire

/* dv/tb_mcu_model.svh */
`ifndef TB_MCU_MODEL_SVH
`define TB_MCU_MODEL_SVH

// model storage, one frame at a time
logic [PIX_W-1:0] frame_y  [MAX_W * MAX_H];
logic [PIX_W-1:0] frame_cb [MAX_W * MAX_H / 4];
logic [PIX_W-1:0] frame_cr [MAX_W * MAX_H / 4];

// expected rows and their row index, oldest first
logic [63:0]      exp_rows [$];
logic [2:0]       exp_idx  [$];

// fibonacci lfsr, taps 32 22 2 1
// one step per bit taken, new bits shift in at the lsb
function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
        state = {state[30:0], fb};
        bits  = {bits[30:0], fb};
    end
    return bits;
endfunction

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("Error at %0d ns: %s is %h, expected %h",
                           $time, name, got, exp));
    end
endtask

// fresh random samples for one frame
// chroma planes are half size in both directions
task automatic fill_frame(input int w, input int h);
    for (int i = 0; i < w * h; i++) begin
        frame_y[i] = 8'(take_bits(stim_state, 8));
    end
    for (int i = 0; i < w * h / 4; i++) begin
        frame_cb[i] = 8'(take_bits(stim_state, 8));
        frame_cr[i] = 8'(take_bits(stim_state, 8));
    end
endtask

// strips top to bottom, macroblocks left to right
// blocks y0 y1 y2 y3 cb cr, eight rows each, samples shifted down by 128
task automatic build_expected(input int w, input int h);
    logic [63:0] row;
    int          px;
    int          ln;
    for (int s = 0; s < h / 16; s++) begin
        for (int m = 0; m < w / 16; m++) begin
            for (int b = 0; b < 6; b++) begin
                for (int r = 0; r < 8; r++) begin
                    for (int k = 0; k < 8; k++) begin
                        if (b < 4) begin
                            // odd luma blocks sit on the right, upper pair on top
                            px = m * 16 + (b % 2) * 8 + k;
                            ln = s * 16 + (b / 2) * 8 + r;
                            row[k*8 +: 8] = frame_y[ln * w + px] - 8'd128;
                        end else begin
                            px = m * 8 + k;
                            ln = s * 8 + r;
                            row[k*8 +: 8] = (b == 4) ? frame_cb[ln * (w / 2) + px] - 8'd128
                                                     : frame_cr[ln * (w / 2) + px] - 8'd128;
                        end
                    end
                    exp_rows.push_back(row);
                    exp_idx.push_back(3'(r));
                end
            end
        end
    end
endtask

`endif

/* dv/tb_jpeg_mcu_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_jpeg_mcu_frontend;

    import jpeg_mcu_pkg::*;

    localparam int MAX_W = 64;
    localparam int MAX_H = 64;
    localparam int XW    = $clog2(MAX_W);
    localparam int YW    = $clog2(MAX_H);
    localparam logic [31:0] SEED = 32'h3d4e_f85e;
    // pixels of all three frames
    localparam int TOTAL_PIX = 32 * 16 + 64 * 64 + 16 * 48;
    // worst case cycles per pixel with gaps, stalls and drain waits
    localparam int SLOWDOWN  = 24;

    logic          clk;
    logic          resetn;
    pix_t          pix_i;
    pix_valid_t    pix_valid_i;
    logic          hold_o;
    logic [XW-1:0] x_size_m1_i;
    logic [YW-1:0] y_size_m1_i;
    row_t          row_o;
    logic          row_valid_o;
    logic [2:0]    row_idx_o;
    logic          hold_i;

    // separate random streams for the source and the consumer
    logic [31:0]   stim_state;
    logic [31:0]   hold_state;
    // consumer stall until both strips are full
    logic          fill_stall;
    int            stall_cycles;
    logic          saw_hold_o;
    // last row seen under stall, must not move
    logic          held_valid;
    row_t          held_row;
    logic [2:0]    held_idx;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    `include "tb_mcu_model.svh"

    jpeg_mcu_frontend #(
        .SENSOR_X_SIZE (MAX_W),
        .SENSOR_Y_SIZE (MAX_H)
    ) i_dut (
        .clk         (clk),
        .resetn      (resetn),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .hold_o      (hold_o),
        .x_size_m1_i (x_size_m1_i),
        .y_size_m1_i (y_size_m1_i),
        .row_o       (row_o),
        .row_valid_o (row_valid_o),
        .row_idx_o   (row_idx_o),
        .hold_i      (hold_i)
    );

    always #10 clk = ~clk;

    initial begin
        repeat (TOTAL_PIX * SLOWDOWN) @(posedge clk);
        fail_run("Timeout: not all expected rows arrived in time");
    end

    // chroma only on even columns of even lines
    task automatic drive_pixel(input int w, input int px, input int ln);
        logic chroma;
        chroma = (px % 2 == 0) && (ln % 2 == 0);
        pix_i.y  = frame_y[ln * w + px];
        pix_i.cb = chroma ? frame_cb[(ln / 2) * (w / 2) + px / 2] : 8'h00;
        pix_i.cr = chroma ? frame_cr[(ln / 2) * (w / 2) + px / 2] : 8'h00;
        pix_valid_i.y  = 1'b1;
        pix_valid_i.cb = chroma;
        pix_valid_i.cr = chroma;
    endtask

    task automatic send_frame(input int w, input int h);
        int strip_rows;
        strip_rows  = (w / 16) * 6 * 8;
        x_size_m1_i = XW'(w - 1);
        y_size_m1_i = YW'(h - 1);
        fill_frame(w, h);
        build_expected(w, h);
        for (int ln = 0; ln < h; ln++) begin
            for (int px = 0; px < w; px++) begin
                // random idle cycles between pixels
                while (take_bits(stim_state, 2) == 32'd0) @(negedge clk);
                // eof restarts the read walk, earlier strips go out first
                if (ln == h - 1 && px == w - 1) begin
                    while (exp_rows.size() != strip_rows || row_valid_o) @(negedge clk);
                end
                drive_pixel(w, px, ln);
                // pixel stays put while the buffer is full
                while (hold_o) @(negedge clk);
                @(negedge clk);
                pix_valid_i = '0;
            end
        end
        // size changes with the next frame, so drain this one
        while (exp_rows.size() != 0 || row_valid_o) @(negedge clk);
    endtask

    // a row is new when the last rising edge was not stalled
    always @(negedge clk) begin
        if (resetn) begin
            saw_hold_o = saw_hold_o | hold_o;
            if (held_valid) begin
                check_value("row_valid_o", 64'(row_valid_o), 64'(1'b1));
                check_value("row_o", row_o, held_row);
                check_value("row_idx_o", 64'(row_idx_o), 64'(held_idx));
            end
            if (row_valid_o && !hold_i) begin
                if (exp_rows.size() == 0) begin
                    fail_run("An output row arrived when no row was expected");
                end
                check_value("row_o", row_o, exp_rows.pop_front());
                check_value("row_idx_o", 64'(row_idx_o), 64'(exp_idx.pop_front()));
            end
            if (fill_stall) begin
                hold_i = 1'b1;
                if (hold_o) begin
                    stall_cycles++;
                end
                if (stall_cycles == 16) begin
                    fill_stall = 1'b0;
                end
            end else begin
                // stall about one cycle in four
                hold_i = (take_bits(hold_state, 2) == 32'd0);
            end
            // the stall just set keeps this row on the output
            held_valid = row_valid_o && hold_i;
            held_row   = row_o;
            held_idx   = row_idx_o;
        end
    end

    initial begin
        clk          = 1'b0;
        resetn       = 1'b0;
        pix_i        = '0;
        pix_valid_i  = '0;
        x_size_m1_i  = '0;
        y_size_m1_i  = '0;
        hold_i       = 1'b0;
        stim_state   = SEED;
        hold_state   = SEED;
        fill_stall   = 1'b0;
        stall_cycles = 0;
        saw_hold_o   = 1'b0;
        held_valid   = 1'b0;
        held_row     = '0;
        held_idx     = '0;
        repeat (2) @(negedge clk);
        resetn = 1'b1;
        repeat (3) @(negedge clk);
        // nothing stored yet
        check_value("row_valid_o", 64'(row_valid_o), 64'(1'b0));
        check_value("hold_o", 64'(hold_o), 64'(1'b0));
        send_frame(32, 16);
        @(posedge clk);
        fill_stall = 1'b1;
        @(negedge clk);
        send_frame(64, 64);
        send_frame(16, 48);
        if (!saw_hold_o) begin
            fail_run("hold_o never rose while the output was stalled");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+dv
common/jpeg_mcu_pkg.sv
verilog/dp_ram_be.sv
verilog/raster_position.sv
mcu_buffer/mcu_buffer.sv
verilog/jpeg_mcu_frontend.sv
dv/tb_jpeg_mcu_frontend.sv

/* Makefile */
# Verilator build and run for the JPEG MCU front end

VERILATOR ?= verilator
TOP       ?= tb_jpeg_mcu_frontend
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
